// ==== bench/adc_capture_tb.sv ====
// ADC capture testbench
`timescale 1ns/100ps
`default_nettype none

module adc_capture_tb;

	import adc_pkg::*;

	localparam int RUN_TIMEOUT = 4000; // a run takes about 820 clocks
	localparam int ADC_TIMEOUT = 100;
	localparam int SETTLE_CYCLES = 40;
	localparam int PAUSE_CYCLES = 50;
	localparam int TOTAL_SHOTS = NUM_PHASES * SHOTS_PER_PHASE;

	logic clk;
	logic rst;
	logic we;
	logic start;
	chan_sel_t trigger_sel;
	sample_t bn = '0;
	logic adc_clk;
	chan_mask_t trigger_vdd;
	chan_mask_t trigger_gnd;
	mean_t mean_0;
	mean_t mean_1;
	mean_t mean_2;
	mean_t mean_3;
	mean_t mean_4;
	logic done;
	logic busy;

	// reference model state
	integer seed = 9;
	chan_sel_t model_sel = 4'd15;
	logic edge_we = 1'b0; // we as seen by the last rising edge
	logic vdd_prev = 1'b0;
	int since_rise = 0;
	int shot_offset = 0;
	int shot_idx = 0;
	int off_sum [NUM_PHASES];

	// trigger waveform tracking
	int level_prev;
	int level_run;
	int shot_count;

	adc_capture_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) edge_we <= we;

	// bn ramps from the supply edge of the selected channel and adds a per-shot offset
	always @(negedge clk) begin
		logic vdd_now;
		vdd_now = (model_sel < NUM_CHAN) ? trigger_vdd[model_sel[1:0]] : 1'b0;
		if (edge_we) begin
			if (vdd_now && !vdd_prev) begin
				since_rise = 0;
				shot_offset = $random(seed) & 32'h3ff;
				if (shot_idx < TOTAL_SHOTS)
					off_sum[shot_idx / SHOTS_PER_PHASE] += shot_offset;
				shot_idx++;
			end else begin
				since_rise++;
			end
			vdd_prev = vdd_now;
		end
		bn <= sample_t'(since_rise + 1 + shot_offset); // counts the coming edge
	end

	task automatic abort_run();
		$display("Finished with errors");
		$fatal(1, "simulation stopped on the first failed check");
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0t: no %s", $time, what);
		abort_run();
	endtask

	task automatic check_mean(input string what, input mean_t got, input mean_t exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_mask(input string what, input chan_mask_t got, input chan_mask_t exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		if (got != exp) begin
			$display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			abort_run();
		end
	endtask

	function automatic mean_t expected_mean(input int k);
		return mean_t'(SAMPLE_DELAY_BASE - k + off_sum[k] / SHOTS_PER_PHASE);
	endfunction

	// level 0 off, 1 ground, 2 supply; run lengths checked at each change
	task automatic track_triggers(input chan_mask_t sel_mask);
		int level;
		check_mask("trigger_gnd outside channel", trigger_gnd & ~sel_mask, '0);
		check_mask("trigger_vdd outside channel", trigger_vdd & ~sel_mask, '0);
		check_bit("ground and supply overlap", |(trigger_gnd & trigger_vdd), 1'b0);
		level = (|trigger_gnd) ? 1 : ((|trigger_vdd) ? 2 : 0);
		if (level == level_prev) begin
			level_run++;
		end else begin
			if (level_prev == 1) begin
				check_count("ground pulse length", level_run, GND_CYCLES);
				check_count("level after ground pulse", level, 0);
			end else if (level_prev == 2) begin
				check_count("supply pulse length", level_run, VDD_CYCLES);
			end else if (level == 2) begin
				check_count("gap length", level_run, GAP_CYCLES);
			end
			if (level == 1)
				shot_count++;
			level_prev = level;
			level_run = 1;
		end
	endtask

	task automatic hold_enable_low(input int cycles);
		chan_mask_t vdd_held;
		chan_mask_t gnd_held;
		vdd_held = trigger_vdd;
		gnd_held = trigger_gnd;
		we = 1'b0;
		repeat (cycles) begin
			@(negedge clk);
			check_mask("trigger_vdd during pause", trigger_vdd, vdd_held);
			check_mask("trigger_gnd during pause", trigger_gnd, gnd_held);
		end
		we = 1'b1;
	endtask

	task automatic wait_adc_rise(output int waited);
		logic prev;
		logic rose;
		waited = 0;
		prev = adc_clk;
		rose = 1'b0;
		while (!rose) begin
			@(negedge clk);
			waited++;
			if (waited > ADC_TIMEOUT)
				report_timeout("rising edge on adc_clk");
			rose = adc_clk && !prev;
			prev = adc_clk;
		end
	endtask

	task automatic check_reset_state();
		check_mask("trigger_vdd after reset", trigger_vdd, '0);
		check_mask("trigger_gnd after reset", trigger_gnd, '0);
		check_bit("done after reset", done, 1'b0);
		check_bit("busy after reset", busy, 1'b0);
		check_bit("adc_clk after reset", adc_clk, 1'b0);
		check_mean("mean_0 after reset", mean_0, '0);
		check_mean("mean_1 after reset", mean_1, '0);
		check_mean("mean_2 after reset", mean_2, '0);
		check_mean("mean_3 after reset", mean_3, '0);
		check_mean("mean_4 after reset", mean_4, '0);
	endtask

	task automatic check_adc_clock();
		int waited;
		logic held;
		wait_adc_rise(waited);
		wait_adc_rise(waited);
		check_count("adc_clk period", waited, 2 * ADC_HALF_PERIOD);
		held = adc_clk;
		we = 1'b0;
		repeat (30) begin
			@(negedge clk);
			check_bit("adc_clk while disabled", adc_clk, held);
		end
		we = 1'b1;
	endtask

	task automatic run_capture(input chan_sel_t sel, input logic extra_start,
			input int pause_at);
		chan_mask_t sel_mask;
		int cycles;
		@(negedge clk);
		sel_mask = (sel < NUM_CHAN) ? chan_mask_t'(1 << sel) : '0;
		shot_idx = 0;
		for (int k = 0; k < NUM_PHASES; k++)
			off_sum[k] = 0;
		level_prev = 0;
		level_run = 0;
		shot_count = 0;
		model_sel = sel;
		trigger_sel = sel;
		start = 1'b1;
		cycles = 0;
		while (!done) begin
			@(negedge clk);
			cycles++;
			if (cycles > RUN_TIMEOUT)
				report_timeout("done pulse at the end of a run");
			start = extra_start && (cycles == 100); // lands while busy
			if (cycles == 1)
				check_bit("busy after start", busy, 1'b1);
			track_triggers(sel_mask);
			if (cycles == pause_at)
				hold_enable_low(PAUSE_CYCLES);
		end
		check_bit("busy at done", busy, 1'b0);
		if (sel < NUM_CHAN) begin
			check_mean("mean_0", mean_0, expected_mean(0));
			check_mean("mean_1", mean_1, expected_mean(1));
			check_mean("mean_2", mean_2, expected_mean(2));
			check_mean("mean_3", mean_3, expected_mean(3));
			check_mean("mean_4", mean_4, expected_mean(4));
		end
		repeat (SETTLE_CYCLES) begin // last supply pulse ends after done
			@(negedge clk);
			check_bit("done after its pulse", done, 1'b0);
			track_triggers(sel_mask);
		end
		check_count("shots in run", shot_count, (sel < NUM_CHAN) ? TOTAL_SHOTS : 0);
	endtask

	initial begin
		rst = 1'b1;
		we = 1'b1;
		start = 1'b0;
		trigger_sel = '0;
		repeat (5) @(negedge clk);
		rst = 1'b0;
		check_reset_state();
		check_adc_clock();
		run_capture(4'd2, 1'b0, 0);
		run_capture(4'd6, 1'b0, 0); // no channel selected
		run_capture(4'd1, 1'b1, 0);
		run_capture(4'd3, 1'b0, 305);
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/bash
# build and run the ADC capture simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module adc_capture_tb \
	-f verilog.f

# a failed check ends in $fatal, which gives a nonzero exit status
./obj_dir/Vadc_capture_tb

// ==== src/adc_capture_top.sv ====
// ADC capture controller top
`timescale 1ns/100ps
`default_nettype none

module adc_capture_top (
	input logic clk,
	input logic rst,
	input logic we,
	input logic start,
	input adc_pkg::chan_sel_t trigger_sel,
	input adc_pkg::sample_t bn,
	output logic adc_clk,
	output adc_pkg::chan_mask_t trigger_vdd,
	output adc_pkg::chan_mask_t trigger_gnd,
	output adc_pkg::mean_t mean_0,
	output adc_pkg::mean_t mean_1,
	output adc_pkg::mean_t mean_2,
	output adc_pkg::mean_t mean_3,
	output adc_pkg::mean_t mean_4,
	output logic done,
	output logic busy
);

	import adc_pkg::*;

	logic adc_tick;
	drive_t drive;
	logic capture;
	phase_t capture_phase;
	logic run_start;
	logic run_end;

	adc_clock_gen u_clock_gen (
		.clk (clk),
		.rst (rst),
		.we (we),
		.adc_clk (adc_clk),
		.adc_tick (adc_tick)
	);

	shot_sequencer u_sequencer (
		.clk (clk),
		.rst (rst),
		.we (we),
		.start (start),
		.adc_tick (adc_tick),
		.drive (drive),
		.capture (capture),
		.capture_phase (capture_phase),
		.run_start (run_start),
		.run_end (run_end),
		.busy (busy)
	);

	trigger_decoder u_decoder (
		.clk (clk),
		.rst (rst),
		.we (we),
		.run_start (run_start),
		.trigger_sel (trigger_sel),
		.drive (drive),
		.trigger_vdd (trigger_vdd),
		.trigger_gnd (trigger_gnd)
	);

	sample_averager u_averager (
		.clk (clk),
		.rst (rst),
		.we (we),
		.capture (capture),
		.run_start (run_start),
		.run_end (run_end),
		.capture_phase (capture_phase),
		.bn (bn),
		.mean_0 (mean_0),
		.mean_1 (mean_1),
		.mean_2 (mean_2),
		.mean_3 (mean_3),
		.mean_4 (mean_4),
		.done (done)
	);

endmodule

`default_nettype wire

// ==== src/adc_clock_gen.sv ====
// ADC clock divider
`timescale 1ns/100ps
`default_nettype none

module adc_clock_gen (
	input logic clk,
	input logic rst,
	input logic we,
	output logic adc_clk,
	output logic adc_tick
);

	import adc_pkg::*;

	logic [DIV_W-1:0] div_cnt;
	logic half_done;

	assign half_done = (div_cnt == DIV_W'(ADC_HALF_PERIOD - 1));

	// half period counter, frozen while we is low
	always_ff @(posedge clk) begin
		if (rst) begin
			div_cnt <= '0;
			adc_clk <= 1'b0;
		end else if (we) begin
			if (half_done) begin
				div_cnt <= '0;
				adc_clk <= ~adc_clk;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	// adc_clk goes high at the coming edge
	assign adc_tick = we & half_done & ~adc_clk;

endmodule

`default_nettype wire

// ==== src/adc_pkg.sv ====
// ADC capture shared definitions
`default_nettype none

package adc_pkg;

	// data widths
	localparam int SAMPLE_W = 14;
	localparam int MEAN_W = 16; // sum of four samples fits
	localparam int NUM_CHAN = 4;

	// run structure
	localparam int NUM_PHASES = 5;
	localparam int SHOTS_PER_PHASE = 4;

	// timing in system clocks
	localparam int ADC_HALF_PERIOD = 10; // 200 MHz in, 10 MHz adc_clk out
	localparam int GND_CYCLES = 8;
	localparam int GAP_CYCLES = 2; // break before make
	localparam int VDD_CYCLES = 24;
	localparam int SAMPLE_DELAY_BASE = 20; // phase k samples at base minus k

	// derived shot timeline
	localparam int VDD_START = GND_CYCLES + GAP_CYCLES;
	localparam int SHOT_CYCLES = VDD_START + VDD_CYCLES;
	localparam int CAPTURE_STEP_BASE = VDD_START + SAMPLE_DELAY_BASE;

	// counter widths
	localparam int DIV_W = $clog2(ADC_HALF_PERIOD);
	localparam int STEP_W = $clog2(SHOT_CYCLES);
	localparam int SHOT_W = $clog2(SHOTS_PER_PHASE);

	typedef logic [SAMPLE_W-1:0] sample_t;
	typedef logic [MEAN_W-1:0] mean_t;
	typedef logic [2:0] phase_t;
	typedef logic [3:0] chan_sel_t; // 4 to 15 select nothing
	typedef logic [NUM_CHAN-1:0] chan_mask_t;

	typedef enum logic [1:0] {
		drive_off = 2'd0,
		drive_gnd = 2'd1,
		drive_vdd = 2'd2
	} drive_t;

endpackage

`default_nettype wire

// ==== src/sample_averager.sv ====
// Per-phase sample averager
`timescale 1ns/100ps
`default_nettype none

module sample_averager (
	input logic clk,
	input logic rst,
	input logic we,
	input logic capture,
	input logic run_start,
	input logic run_end,
	input adc_pkg::phase_t capture_phase,
	input adc_pkg::sample_t bn,
	output adc_pkg::mean_t mean_0,
	output adc_pkg::mean_t mean_1,
	output adc_pkg::mean_t mean_2,
	output adc_pkg::mean_t mean_3,
	output adc_pkg::mean_t mean_4,
	output logic done
);

	import adc_pkg::*;

	mean_t acc [NUM_PHASES]; // running sums, one per phase
	mean_t mean_q [NUM_PHASES];

	// accumulate the captured words of the current phase
	always_ff @(posedge clk) begin
		if (we) begin
			if (run_start) begin
				for (int k = 0; k < NUM_PHASES; k++) begin
					acc[k] <= '0;
				end
			end else if (capture) begin
				acc[capture_phase] <= acc[capture_phase] + MEAN_W'(bn);
			end
		end
	end

	// publish at run end, means hold until the next run completes
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < NUM_PHASES; k++) begin
				mean_q[k] <= '0;
			end
			done <= 1'b0;
		end else if (we) begin
			if (run_end) begin
				for (int k = 0; k < NUM_PHASES; k++) begin
					mean_q[k] <= acc[k] >> 2; // four shots per phase
				end
			end
			done <= run_end;
		end
	end

	assign mean_0 = mean_q[0];
	assign mean_1 = mean_q[1];
	assign mean_2 = mean_q[2];
	assign mean_3 = mean_q[3];
	assign mean_4 = mean_q[4];

endmodule

`default_nettype wire

// ==== src/shot_sequencer.sv ====
// Trigger shot sequencer
`timescale 1ns/100ps
`default_nettype none

module shot_sequencer (
	input logic clk,
	input logic rst,
	input logic we,
	input logic start,
	input logic adc_tick,
	output adc_pkg::drive_t drive,
	output logic capture,
	output adc_pkg::phase_t capture_phase,
	output logic run_start,
	output logic run_end,
	output logic busy
);

	import adc_pkg::*;

	phase_t phase;
	logic [SHOT_W-1:0] shot_cnt;
	logic [STEP_W-1:0] step;
	logic [STEP_W-1:0] capture_step;
	logic in_shot; // a shot timeline is running
	logic shot_done;
	logic last_shot;
	logic last_phase;

	assign run_start = start & we & ~busy; // ignored while a run is active

	assign shot_done = in_shot & (step == STEP_W'(SHOT_CYCLES - 1));
	assign last_shot = (shot_cnt == SHOT_W'(SHOTS_PER_PHASE - 1));
	assign last_phase = (phase == phase_t'(NUM_PHASES - 1));

	assign run_end = we & shot_done & last_shot & last_phase;

	// phase, shot and step walk
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			in_shot <= 1'b0;
			step <= '0;
			shot_cnt <= '0;
			phase <= '0;
		end else if (we) begin
			if (run_start) begin
				busy <= 1'b1;
				shot_cnt <= '0;
				phase <= '0;
			end else if (busy) begin
				if (!in_shot) begin
					if (adc_tick) begin // shots align to adc_clk rising edges
						in_shot <= 1'b1;
						step <= '0;
					end
				end else if (shot_done) begin
					in_shot <= 1'b0;
					if (last_shot) begin
						shot_cnt <= '0;
						if (last_phase)
							busy <= 1'b0;
						else
							phase <= phase + phase_t'(1);
					end else begin
						shot_cnt <= shot_cnt + 1'b1;
					end
				end else begin
					step <= step + 1'b1;
				end
			end
		end
	end

	// ground, gap, then supply; off outside a shot
	always_comb begin
		drive = drive_off;
		if (in_shot) begin
			if (step < STEP_W'(GND_CYCLES))
				drive = drive_gnd;
			else if (step >= STEP_W'(VDD_START))
				drive = drive_vdd;
		end
	end

	// the decoder register puts the trigger_vdd edge one clock after the
	// first vdd step, so counting from that step lands bn on the wanted edge
	assign capture_step = STEP_W'(CAPTURE_STEP_BASE) - STEP_W'(phase);

	assign capture = we & in_shot & (step == capture_step);
	assign capture_phase = phase;

endmodule

`default_nettype wire

// ==== src/trigger_decoder.sv ====
// Trigger switch decoder
`timescale 1ns/100ps
`default_nettype none

module trigger_decoder (
	input logic clk,
	input logic rst,
	input logic we,
	input logic run_start,
	input adc_pkg::chan_sel_t trigger_sel,
	input adc_pkg::drive_t drive,
	output adc_pkg::chan_mask_t trigger_vdd,
	output adc_pkg::chan_mask_t trigger_gnd
);

	import adc_pkg::*;

	chan_sel_t sel_q;
	chan_mask_t chan_mask;

	// channel held for the whole run
	always_ff @(posedge clk) begin
		if (rst)
			sel_q <= '0;
		else if (we && run_start)
			sel_q <= trigger_sel;
	end

	// one-hot channel, empty for out of range selections
	always_comb begin
		chan_mask = '0;
		for (int i = 0; i < NUM_CHAN; i++) begin
			if (sel_q == chan_sel_t'(i))
				chan_mask[i] = 1'b1;
		end
	end

	// drive level is exclusive, so vdd and gnd never overlap
	always_ff @(posedge clk) begin
		if (rst) begin
			trigger_vdd <= '0;
			trigger_gnd <= '0;
		end else if (we) begin
			trigger_vdd <= (drive == drive_vdd) ? chan_mask : '0;
			trigger_gnd <= (drive == drive_gnd) ? chan_mask : '0;
		end
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/adc_pkg.sv
src/adc_clock_gen.sv
src/shot_sequencer.sv
src/trigger_decoder.sv
src/sample_averager.sv
src/adc_capture_top.sv
bench/adc_capture_tb.sv
